// File: fpuExec.f
+incdir+design
+incdir+sim
design/fpuPkg.sv
design/fpCompare.sv
design/fpToInt.sv
design/intToFp.sv
design/fpuUnit.sv
design/fcsrReg.sv
design/fpuTop.sv
sim/fpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module fpuTb -f fpuExec.f -o simFpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simFpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sim/fpuModel.svh
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

function automatic logic isNan(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
endfunction

function automatic logic isSnan(input logic [31:0] x);
    return isNan(x) && !x[22];
endfunction

// Signed key that orders non-NaN floats, both zeros map to 0
function automatic longint orderKey(input logic [31:0] x);
    longint m;
    m = longint'({33'b0, x[30:0]});
    return x[31] ? -m : m;
endfunction

// Round away from truncation, judged on the discarded remainder
function automatic logic wantUp(input logic [2:0] rm, input logic neg, input logic odd,
                                input longint rem, input longint half);
    if (rem == 0)
        return 1'b0;
    case (rm)
        3'd1:    return 1'b0;
        3'd2:    return neg;
        3'd3:    return !neg;
        3'd4:    return rem >= half;
        default: return (rem > half) || ((rem == half) && odd);
    endcase
endfunction

// Returns {NV DZ OF UF NX, value}
function automatic logic [36:0] cvtToInt(input logic [31:0] x, input logic [2:0] rm,
                                         input logic sgn);
    logic   neg, ovf;
    int     e, sh;
    longint m, ip, rem, half, magR;
    neg  = x[31];
    e    = int'({24'b0, x[30:23]});
    m    = longint'({40'b0, (e != 0), x[22:0]});
    rem  = 0;
    magR = 0;
    ovf  = 1'b0;
    if (isNan(x))
        return {5'b10000, (sgn ? 32'h7FFF_FFFF : 32'hFFFF_FFFF)};
    if (e >= 159) begin
        ovf = 1'b1;
    end else if (e >= 150) begin
        magR = m << (e - 150);
    end else begin
        sh   = (150 - e > 40) ? 40 : 150 - e;
        ip   = m >> sh;
        rem  = m - (ip << sh);
        half = longint'(1) << (sh - 1);
        magR = ip + longint'(wantUp(rm, neg, ip[0], rem, half));
    end
    if (sgn)
        ovf = ovf || (neg ? magR > 64'h8000_0000 : magR > 64'h7FFF_FFFF);
    else
        ovf = ovf || (neg ? magR != 0 : magR > 64'hFFFF_FFFF);
    if (ovf)
        return {5'b10000, neg ? (sgn ? 32'h8000_0000 : 32'h0) : (sgn ? 32'h7FFF_FFFF : 32'hFFFF_FFFF)};
    return {4'b0000, (rem != 0), (neg ? (~magR[31:0] + 32'd1) : magR[31:0])};
endfunction

function automatic logic [36:0] cvtToFloat(input logic [31:0] x, input logic [2:0] rm,
                                           input logic sgn);
    logic   neg;
    int     p, sh;
    longint mag, q, rem, half;
    neg = sgn && x[31];
    mag = neg ? (64'h1_0000_0000 - {32'b0, x}) : {32'b0, x};
    rem = 0;
    p   = 0;
    if (mag == 0)
        return 37'd0;
    for (int i = 0; i < 33; i++)
        if (mag[i])
            p = i;
    if (p <= 23) begin
        q = mag << (23 - p);
    end else begin
        sh   = p - 23;
        q    = mag >> sh;
        rem  = mag - (q << sh);
        half = longint'(1) << (sh - 1);
        q    = q + longint'(wantUp(rm, neg, q[0], rem, half));
        if (q == (longint'(1) << 24)) begin  // Mantissa carry
            q = q >> 1;
            p = p + 1;
        end
    end
    return {4'b0000, (rem != 0), neg, 8'(127 + p), q[22:0]};
endfunction

function automatic logic [36:0] modelExec(input fpuPkg::fpuOpT op, input logic [2:0] rm,
                                          input logic [31:0] a, input logic [31:0] b);
    logic   nanA, nanB, sAny, unord;
    longint ka, kb;
    logic [31:0] lo, hi;
    nanA  = isNan(a);
    nanB  = isNan(b);
    sAny  = isSnan(a) || isSnan(b);
    unord = nanA || nanB;
    ka    = orderKey(a);
    kb    = orderKey(b);
    lo    = (ka < kb) ? a : (ka > kb) ? b : (a[31] ? a : b);
    hi    = (ka > kb) ? a : (ka < kb) ? b : (a[31] ? b : a);
    case (op)
        fpuPkg::FEQ:    return {sAny, 4'b0, 31'b0, !unord && (ka == kb)};
        fpuPkg::FLT:    return {unord, 4'b0, 31'b0, !unord && (ka < kb)};
        fpuPkg::FLE:    return {unord, 4'b0, 31'b0, !unord && (ka <= kb)};
        fpuPkg::FMIN,
        fpuPkg::FMAX: begin
            if (nanA && nanB)
                return {sAny, 4'b0, `CANON_NAN};
            if (nanA || nanB)
                return {sAny, 4'b0, (nanA ? b : a)};
            return {sAny, 4'b0, ((op == fpuPkg::FMIN) ? lo : hi)};
        end
        fpuPkg::FSGNJ:   return {5'b0, b[31], a[30:0]};
        fpuPkg::FSGNJN:  return {5'b0, !b[31], a[30:0]};
        fpuPkg::FSGNJX:  return {5'b0, a[31] ^ b[31], a[30:0]};
        fpuPkg::FCVTWS:  return cvtToInt(a, rm, 1'b1);
        fpuPkg::FCVTWUS: return cvtToInt(a, rm, 1'b0);
        fpuPkg::FCVTSW:  return cvtToFloat(a, rm, 1'b1);
        fpuPkg::FCVTSWU: return cvtToFloat(a, rm, 1'b0);
        default:         return {5'b0, a};  // Raw moves
    endcase
endfunction

function automatic fpuPkg::flagT prioFlag(input logic [4:0] bits, input logic illegal);
    if (illegal) return fpuPkg::ILLEGAL;
    if (bits[4]) return fpuPkg::NV;
    if (bits[3]) return fpuPkg::DZ;
    if (bits[2]) return fpuPkg::OF;
    if (bits[1]) return fpuPkg::UF;
    if (bits[0]) return fpuPkg::NX;
    return fpuPkg::NONE;
endfunction

`endif

// File: sim/fpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpuDefs.svh"

module fpuTb;

    `include "fpuModel.svh"

    localparam int TOTAL_OPS   = 900;
    localparam int WATCHDOG_NS = TOTAL_OPS * 100 + 50000;

    typedef struct packed {
        logic [31:0]  res;
        fpuPkg::flagT flags;
        logic [4:0]   bits;
        logic [5:0]   tag;
        logic [6:0]   sq;
        logic [31:0]  pc;
        logic         checkRes;
        logic [31:0]  cycle;
    } expT;

    logic clk = 1'b0;
    logic rst, en, csrWe;
    fpuPkg::fpUopT  uop;
    fpuPkg::branchT branch;
    fpuPkg::rmT     csrFrm, frm;
    fpuPkg::fpResT  result;
    logic [4:0]     fflags;

    expT   expQ[$];
    string nameQ[$];
    string curName;
    logic [31:0] rngState = 32'd3981;
    logic [31:0] cycles = 0;
    logic [31:0] specials[16];
    logic [6:0]  nextSq = 0;
    logic [5:0]  tagCnt = 0;
    logic [2:0]  tbFrm = 3'd0;
    logic [4:0]  expFflags = 0;
    int errors = 0, checks = 0, tests = 0, testErr0 = 0;

    fpuTop i_fpuTop (
        .clk(clk), .rst(rst), .en(en), .uop(uop), .branch(branch),
        .csrWe(csrWe), .csrFrm(csrFrm), .result(result), .frm(frm), .fflags(fflags)
    );

    always #50 clk = ~clk;
    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] xorshift();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Specials, random bits, or a float in the conversion range
    function automatic logic [31:0] pickFloat();
        logic [31:0] r;
        r = xorshift();
        if (r[2:0] < 3'd2)
            return specials[r[7:4]];
        if (r[2:0] == 3'd2)
            return xorshift();
        return {r[31], 8'd120 + 8'(r[15:8] % 8'd40), r[30:8]};
    endfunction

    function automatic logic [31:0] pickInt();
        logic [31:0] r;
        r = xorshift();
        case (r[1:0])
            2'd0:    return specials[r[7:4]];
            2'd1:    return xorshift();
            2'd2:    return xorshift() & 32'h01FF_FFFF;
            default: return -(xorshift() & 32'h0FFF_FFFF);
        endcase
    endfunction

    function automatic logic younger(input logic [6:0] sq, input logic [6:0] br);
        logic [6:0] d;
        d = sq - br;
        return (d != 7'd0) && !d[6];
    endfunction

    task automatic issue(input fpuPkg::fpuOpT op, input logic [2:0] rm, input logic [31:0] a,
                         input logic [31:0] b, input logic enable);
        expT         e;
        logic [2:0]  eff;
        logic [36:0] m;
        logic        illegal;
        @(negedge clk);
        uop.valid  = 1'b1;
        uop.opcode = op;
        uop.rm     = fpuPkg::rmT'(rm);
        uop.srcA   = a;
        uop.srcB   = b;
        uop.tagDst = tagCnt;
        uop.sqN    = nextSq;
        uop.pc     = 32'h8000_0000 + {23'b0, nextSq, 2'b00};
        en         = enable;
        if (enable && !(branch.taken && younger(nextSq, branch.sqN))) begin
            eff        = (rm == 3'd7) ? tbFrm : rm;
            illegal    = eff > 3'd4;
            m          = modelExec(op, eff, a, b);
            e.res      = m[31:0];
            e.flags    = prioFlag(m[36:32], illegal);
            e.bits     = m[36:32];
            e.tag      = tagCnt;
            e.sq       = nextSq;
            e.pc       = uop.pc;
            e.checkRes = !illegal;
            e.cycle    = cycles;
            expQ.push_back(e);
            nameQ.push_back(curName);
            if (!illegal)
                expFflags = expFflags | m[36:32];
        end
        if (enable) begin
            nextSq = nextSq + 7'd1;
            tagCnt = tagCnt + 6'd1;
        end
    endtask

    task automatic setFrm(input logic [2:0] m);
        @(negedge clk);
        uop.valid = 1'b0;
        csrWe     = 1'b1;
        csrFrm    = fpuPkg::rmT'(m);
        @(negedge clk);
        csrWe = 1'b0;
        tbFrm = m;
        if (frm != m) begin
            $display("Fail %s: frm expected %0d actual %0d", curName, m, frm);
            errors++;
        end
        checks++;
    endtask

    task automatic setBranch(input logic taken, input logic [6:0] sq);
        @(negedge clk);
        uop.valid    = 1'b0;
        branch.taken = taken;
        branch.sqN   = sq;
    endtask

    task automatic startTest(input string name);
        curName  = name;
        testErr0 = errors;
    endtask

    task automatic finishTest();
        @(negedge clk);
        uop.valid = 1'b0;
        en        = 1'b1;
        while (expQ.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
        tests++;
        $display("Test %s: %s, %0d errors", curName,
                 (errors == testErr0) ? "ok" : "FAILED", errors - testErr0);
    endtask

    // ==================================================================
    // Result checker
    // ==================================================================

    initial begin
        expT   e;
        string n;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && result.valid) begin
                if (expQ.size() == 0) begin
                    $display("Result with tag %0d arrived with no micro-op outstanding",
                             result.tagDst);
                    errors++;
                end else begin
                    e = expQ.pop_front();
                    n = nameQ.pop_front();
                    checks++;
                    if (e.checkRes && result.result != e.res) begin
                        $display("Fail %s: result expected %h actual %h", n, e.res, result.result);
                        errors++;
                    end
                    if (result.flags != e.flags) begin
                        $display("Fail %s: flags expected %0d actual %0d", n, e.flags, result.flags);
                        errors++;
                    end
                    if (e.checkRes && result.fflagBits != e.bits) begin
                        $display("Fail %s: flag bits expected %b actual %b", n, e.bits,
                                 result.fflagBits);
                        errors++;
                    end
                    if (result.tagDst != e.tag) begin
                        $display("Fail %s: tag expected %0d actual %0d", n, e.tag, result.tagDst);
                        errors++;
                    end
                    if (result.sqN != e.sq) begin
                        $display("Fail %s: sqN expected %0d actual %0d", n, e.sq, result.sqN);
                        errors++;
                    end
                    if (result.pc != e.pc) begin
                        $display("Fail %s: pc expected %h actual %h", n, e.pc, result.pc);
                        errors++;
                    end
                    if (cycles != e.cycle + 1) begin
                        $display("Result for %s came %0d cycles after issue instead of one",
                                 n, cycles - e.cycle);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    // ==================================================================
    // Stimulus
    // ==================================================================

    initial begin
        logic [6:0] brSq;
        specials = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                     32'h7FC0_0000, 32'h7F80_0001, 32'h3F00_0000, 32'h3FC0_0000,
                     32'h4020_0000, 32'hC020_0000, 32'h4060_0000, 32'hBF00_0000,
                     32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0100_0001};
        rst    = 1'b1;
        en     = 1'b0;
        csrWe  = 1'b0;
        csrFrm = fpuPkg::RNE;
        uop    = '0;
        branch = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        startTest("compare");
        repeat (200)
            issue(fpuPkg::fpuOpT'(4'(xorshift() % 8)), 3'd0, pickFloat(), pickFloat(), 1'b1);
        finishTest();

        startTest("fpToInt");
        for (int rm = 0; rm < 5; rm++)
            for (int s = 0; s < 2; s++)
                repeat (30)
                    issue(s ? fpuPkg::FCVTWS : fpuPkg::FCVTWUS, 3'(rm), pickFloat(), 0, 1'b1);
        finishTest();

        startTest("intToFp");
        for (int rm = 0; rm < 5; rm++)
            for (int s = 0; s < 2; s++)
                repeat (30)
                    issue(s ? fpuPkg::FCVTSW : fpuPkg::FCVTSWU, 3'(rm), pickInt(), 0, 1'b1);
        issue(fpuPkg::FMVXW, 3'd0, 32'h7F80_0001, 0, 1'b1);
        issue(fpuPkg::FMVWX, 3'd0, 32'hDEAD_BEEF, 0, 1'b1);
        finishTest();

        startTest("dynamicRm");
        setFrm(3'd3);
        repeat (10) issue(fpuPkg::FCVTSW, 3'd7, pickInt(), 0, 1'b1);
        setFrm(3'd2);
        repeat (10) issue(fpuPkg::FCVTWS, 3'd7, pickFloat(), 0, 1'b1);
        issue(fpuPkg::FCVTWS, 3'd5, 32'h3FC0_0000, 0, 1'b1);
        issue(fpuPkg::FEQ, 3'd6, 32'h3F80_0000, 32'h3F80_0000, 1'b1);
        setFrm(3'd5);
        issue(fpuPkg::FCVTSW, 3'd7, 32'h0100_0001, 0, 1'b1);
        setFrm(3'd0);
        finishTest();

        startTest("squashStall");
        brSq = nextSq;
        setBranch(1'b1, brSq);
        nextSq = brSq + 7'd1;
        repeat (3) issue(fpuPkg::FMVXW, 3'd0, xorshift(), 0, 1'b1);  // Squashed
        nextSq = brSq - 7'd2;
        repeat (3) issue(fpuPkg::FMVXW, 3'd0, xorshift(), 0, 1'b1);  // Older or equal
        setBranch(1'b1, 7'd126);
        nextSq = 7'd1;
        issue(fpuPkg::FMVXW, 3'd0, xorshift(), 0, 1'b1);  // Younger across wraparound
        nextSq = 7'd120;
        issue(fpuPkg::FMVXW, 3'd0, xorshift(), 0, 1'b1);
        setBranch(1'b0, 7'd0);
        repeat (3) issue(fpuPkg::FSGNJN, 3'd0, 32'h4020_0000, 32'h0, 1'b0);
        issue(fpuPkg::FSGNJN, 3'd0, 32'h4020_0000, 32'h0, 1'b1);
        repeat (20)
            issue(fpuPkg::fpuOpT'(4'(xorshift() % 8)), 3'd0, pickFloat(), pickFloat(), 1'b1);
        finishTest();

        startTest("fflags");
        if (fflags != expFflags) begin
            $display("Fail fflags: expected %b actual %b", expFflags, fflags);
            errors++;
        end
        checks++;
        finishTest();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/fpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module fpuTop (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 en,
    input  wire fpuPkg::fpUopT  uop,
    input  wire fpuPkg::branchT branch,
    input  wire                 csrWe,
    input  wire fpuPkg::rmT     csrFrm,
    output fpuPkg::fpResT       result,
    output fpuPkg::rmT          frm,
    output logic [4:0]          fflags
);

    // Result loops back for flag accumulation
    fcsrReg i_fcsrReg (
        .clk    (clk),
        .rst    (rst),
        .csrWe  (csrWe),
        .csrFrm (csrFrm),
        .result (result),
        .frm    (frm),
        .fflags (fflags)
    );

    fpuUnit i_fpuUnit (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .uop    (uop),
        .branch (branch),
        .frm    (frm),
        .result (result)
    );

endmodule

`default_nettype wire

// File: design/fcsrReg.sv
`timescale 1ns/1ps
`default_nettype none

module fcsrReg (
    input  wire                clk,
    input  wire                rst,
    input  wire                csrWe,
    input  wire fpuPkg::rmT    csrFrm,
    input  wire fpuPkg::fpResT result,
    output fpuPkg::rmT         frm,
    output logic [4:0]         fflags
);

    logic accumulate;

    // ==================================================================
    // Dynamic rounding mode
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            frm <= fpuPkg::RNE;
        end else if (csrWe) begin
            frm <= csrFrm;  // Reserved values pass through, caught in the unit
        end
    end

    // ==================================================================
    // Sticky exception flags
    // ==================================================================

    // Illegal micro-ops trap instead of raising flags
    assign accumulate = result.valid && (result.flags != fpuPkg::ILLEGAL);

    always_ff @(posedge clk) begin
        if (rst) begin
            fflags <= '0;
        end else if (accumulate) begin
            fflags <= fflags | result.fflagBits;
        end
    end

endmodule

`default_nettype wire

// File: design/fpuUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpuDefs.svh"

module fpuUnit (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 en,
    input  wire fpuPkg::fpUopT  uop,
    input  wire fpuPkg::branchT branch,
    input  wire fpuPkg::rmT     frm,
    output fpuPkg::fpResT       result
);

    fpuPkg::rmT       effRm;
    fpuPkg::flagT     flagNext;
    logic             illegalRm, signaling, squashed, accept;
    logic [`SQN_W-1:0] sqDiff;
    logic             lessThan, equal;
    logic [`FLEN-1:0] minResult, maxResult, sgnjResult, sgnjnResult, sgnjxResult;
    logic [4:0]       cmpFlags, bitsNext;
    logic [`XLEN-1:0] toInt;
    logic             toIntInvalid, toIntInexact;
    logic [`FLEN-1:0] fromInt;
    logic             fromIntInexact;
    logic [`FLEN-1:0] resNext;

    assign effRm     = (uop.rm == fpuPkg::DYN) ? frm : uop.rm;
    assign illegalRm = effRm > fpuPkg::RMM;  // 5, 6, or DYN left in frm
    assign signaling = (uop.opcode == fpuPkg::FLT) || (uop.opcode == fpuPkg::FLE);

    fpCompare i_fpCompare (
        .srcA        (uop.srcA),
        .srcB        (uop.srcB),
        .signaling   (signaling),
        .lessThan    (lessThan),
        .equal       (equal),
        .greaterThan (),
        .minResult   (minResult),
        .maxResult   (maxResult),
        .sgnjResult  (sgnjResult),
        .sgnjnResult (sgnjnResult),
        .sgnjxResult (sgnjxResult),
        .cmpFlags    (cmpFlags)
    );

    fpToInt i_fpToInt (
        .src       (uop.srcA),
        .rm        (effRm),
        .signedOut (uop.opcode == fpuPkg::FCVTWS),
        .intOut    (toInt),
        .invalid   (toIntInvalid),
        .inexact   (toIntInexact)
    );

    intToFp i_intToFp (
        .intIn    (uop.srcA),
        .rm       (effRm),
        .signedIn (uop.opcode == fpuPkg::FCVTSW),
        .fpOut    (fromInt),
        .inexact  (fromIntInexact)
    );

    // ==================================================================
    // Result and flag select
    // ==================================================================

    always_comb begin
        bitsNext = '0;
        case (uop.opcode)
            fpuPkg::FEQ:     resNext = {31'b0, equal};
            fpuPkg::FLT:     resNext = {31'b0, lessThan};
            fpuPkg::FLE:     resNext = {31'b0, lessThan || equal};
            fpuPkg::FMIN:    resNext = minResult;
            fpuPkg::FMAX:    resNext = maxResult;
            fpuPkg::FSGNJ:   resNext = sgnjResult;
            fpuPkg::FSGNJN:  resNext = sgnjnResult;
            fpuPkg::FSGNJX:  resNext = sgnjxResult;
            fpuPkg::FCVTWS,
            fpuPkg::FCVTWUS: resNext = toInt;
            fpuPkg::FCVTSW,
            fpuPkg::FCVTSWU: resNext = fromInt;
            fpuPkg::FMVXW,
            fpuPkg::FMVWX:   resNext = uop.srcA;  // Raw bit move
            default:         resNext = '0;
        endcase
        case (uop.opcode)
            fpuPkg::FEQ, fpuPkg::FLT, fpuPkg::FLE,
            fpuPkg::FMIN, fpuPkg::FMAX:      bitsNext = cmpFlags;
            fpuPkg::FCVTWS, fpuPkg::FCVTWUS: bitsNext = {toIntInvalid, 3'b000, toIntInexact};
            fpuPkg::FCVTSW, fpuPkg::FCVTSWU: bitsNext = {4'b0000, fromIntInexact};
            default:                         bitsNext = '0;
        endcase
    end

    // Priority NV, DZ, OF, UF, NX
    always_comb begin
        if (illegalRm)        flagNext = fpuPkg::ILLEGAL;
        else if (bitsNext[4]) flagNext = fpuPkg::NV;
        else if (bitsNext[3]) flagNext = fpuPkg::DZ;
        else if (bitsNext[2]) flagNext = fpuPkg::OF;
        else if (bitsNext[1]) flagNext = fpuPkg::UF;
        else if (bitsNext[0]) flagNext = fpuPkg::NX;
        else                  flagNext = fpuPkg::NONE;
    end

    // Younger than the taken branch across wraparound
    assign sqDiff   = uop.sqN - branch.sqN;
    assign squashed = branch.taken && !sqDiff[`SQN_W-1] && (sqDiff != '0);
    assign accept   = en && uop.valid && !squashed;

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else if (accept) begin
            result.valid     <= 1'b1;
            result.tagDst    <= uop.tagDst;
            result.sqN       <= uop.sqN;
            result.pc        <= uop.pc;
            result.result    <= resNext;
            result.flags     <= flagNext;
            result.fflagBits <= bitsNext;
        end else begin
            result.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/intToFp.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpuDefs.svh"

module intToFp (
    input  wire [`XLEN-1:0] intIn,
    input  wire fpuPkg::rmT rm,
    input  wire             signedIn,
    output logic [`FLEN-1:0] fpOut,
    output logic            inexact
);

    logic             neg;
    logic [`XLEN-1:0] mag;
    logic [`XLEN-1:0] norm;
    logic [4:0]       lzc;
    logic             guard, sticky, roundUp;
    logic [24:0]      sum;
    logic [7:0]       expOut;

    assign neg = signedIn && intIn[`XLEN-1];
    assign mag = neg ? -intIn : intIn;  // 0x80000000 stays as is

    // ==================================================================
    // Normalize
    // ==================================================================

    // Highest set bit wins
    always_comb begin
        lzc = '0;
        for (int i = 0; i < `XLEN; i++) begin
            if (mag[i])
                lzc = 5'(`XLEN - 1 - i);
        end
    end

    assign norm = mag << lzc;

    // 24-bit significand, bits below feed rounding
    assign guard  = norm[7];
    assign sticky = |norm[6:0];

    // ==================================================================
    // Round
    // ==================================================================

    assign roundUp = fpuPkg::roundIncr(rm, neg, norm[8], guard, sticky);
    assign sum     = {1'b0, norm[31:8]} + 25'(roundUp);

    // Carry out of the significand bumps the exponent
    assign expOut = 8'd158 - {3'b0, lzc} + {7'b0, sum[24]};

    always_comb begin
        if (mag == '0)
            fpOut = '0;  // Always +0
        else
            fpOut = {neg, expOut, sum[22:0]};
    end

    assign inexact = guard || sticky;

endmodule

`default_nettype wire

// File: design/fpToInt.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpuDefs.svh"

module fpToInt (
    input  wire [`FLEN-1:0] src,
    input  wire fpuPkg::rmT rm,
    input  wire             signedOut,
    output logic [`XLEN-1:0] intOut,
    output logic            invalid,
    output logic            inexact
);

    logic        sign, isNaN, tooBig;
    logic [7:0]  expIn;
    logic [23:0] sig;
    logic [49:0] frac;
    logic [32:0] mag, rounded;
    logic [4:0]  rShift;
    logic [3:0]  lShift;
    logic        guard, sticky, roundUp;
    logic        posOvf, negOvf;

    assign sign   = src[`FLEN-1];
    assign expIn  = src[30:23];
    assign sig    = {|expIn, src[22:0]};  // Hidden bit
    assign isNaN  = (&expIn) && (|src[22:0]);
    assign tooBig = expIn >= 8'd159;      // |x| >= 2^32, also inf

    // Align to the binary point
    always_comb begin
        lShift = '0;
        rShift = '0;
        frac   = '0;
        guard  = 1'b0;
        sticky = 1'b0;
        if (expIn >= 8'd150) begin
            lShift = 4'(expIn - 8'd150);
            mag    = {9'b0, sig} << lShift;
        end else begin
            rShift = (expIn < 8'd125) ? 5'd25 : 5'(8'd150 - expIn);
            frac   = {sig, 26'b0} >> rShift;
            mag    = {9'b0, frac[49:26]};
            guard  = frac[25];
            sticky = |frac[24:0];
        end
    end

    assign roundUp = fpuPkg::roundIncr(rm, sign, mag[0], guard, sticky);
    assign rounded = mag + 33'(roundUp);

    always_comb begin
        if (signedOut) begin
            posOvf = !sign && (tooBig || rounded > 33'h0_7FFF_FFFF);
            negOvf = sign && (tooBig || rounded > 33'h0_8000_0000);
        end else begin
            posOvf = !sign && (tooBig || rounded[32]);
            negOvf = sign && (tooBig || rounded != '0);  // -1.0 and below
        end
    end

    always_comb begin
        invalid = isNaN || posOvf || negOvf;
        if (isNaN || posOvf)
            intOut = signedOut ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
        else if (negOvf)
            intOut = signedOut ? 32'h8000_0000 : 32'h0000_0000;
        else if (sign)
            intOut = -rounded[31:0];
        else
            intOut = rounded[31:0];
        inexact = (guard || sticky) && !invalid;
    end

endmodule

`default_nettype wire

// File: design/fpCompare.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpuDefs.svh"

module fpCompare (
    input  wire [`FLEN-1:0] srcA,
    input  wire [`FLEN-1:0] srcB,
    input  wire             signaling,
    output logic            lessThan,
    output logic            equal,
    output logic            greaterThan,
    output logic [`FLEN-1:0] minResult,
    output logic [`FLEN-1:0] maxResult,
    output logic [`FLEN-1:0] sgnjResult,
    output logic [`FLEN-1:0] sgnjnResult,
    output logic [`FLEN-1:0] sgnjxResult,
    output logic [4:0]      cmpFlags
);

    logic             signA, signB;
    logic [`FLEN-2:0] magA, magB;
    logic             aNaN, bNaN, aSNaN, bSNaN;
    logic             unordered, bothZero;
    logic             aBelowB;

    assign signA = srcA[`FLEN-1];
    assign signB = srcB[`FLEN-1];
    assign magA  = srcA[`FLEN-2:0];
    assign magB  = srcB[`FLEN-2:0];

    // NaN classes, quiet bit is the top mantissa bit
    assign aNaN  = (&srcA[30:23]) && (|srcA[22:0]);
    assign bNaN  = (&srcB[30:23]) && (|srcB[22:0]);
    assign aSNaN = aNaN && !srcA[22];
    assign bSNaN = bNaN && !srcB[22];

    assign unordered = aNaN || bNaN;
    assign bothZero  = (magA == '0) && (magB == '0);  // +0 == -0

    always_comb begin
        if (signA != signB)
            aBelowB = signA;
        else if (signA)
            aBelowB = magA > magB;  // Both negative
        else
            aBelowB = magA < magB;
    end

    assign equal       = !unordered && ((srcA == srcB) || bothZero);
    assign lessThan    = !unordered && !equal && aBelowB;
    assign greaterThan = !unordered && !equal && !aBelowB;

    // ==================================================================
    // Min / max
    // ==================================================================

    always_comb begin
        if (aNaN && bNaN)
            minResult = `CANON_NAN;
        else if (bNaN)
            minResult = srcA;
        else if (aNaN)
            minResult = srcB;
        else if (lessThan || (equal && signA && !signB))
            minResult = srcA;  // -0 below +0
        else
            minResult = srcB;

        if (aNaN && bNaN)
            maxResult = `CANON_NAN;
        else if (bNaN)
            maxResult = srcA;
        else if (aNaN)
            maxResult = srcB;
        else if (greaterThan || (equal && !signA && signB))
            maxResult = srcA;
        else
            maxResult = srcB;
    end

    assign sgnjResult  = {signB, magA};
    assign sgnjnResult = {!signB, magA};
    assign sgnjxResult = {signA ^ signB, magA};

    assign cmpFlags = {aSNaN || bSNaN || (signaling && unordered), 4'b0000};

endmodule

`default_nettype wire

// File: design/fpuPkg.sv
`default_nettype none

`include "fpuDefs.svh"

package fpuPkg;

    typedef enum logic [3:0] {
        FEQ, FLT, FLE,
        FMIN, FMAX,
        FSGNJ, FSGNJN, FSGNJX,
        FCVTWS, FCVTWUS,
        FCVTSW, FCVTSWU,
        FMVXW, FMVWX
    } fpuOpT;

    // 5 and 6 are reserved encodings
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4,
        DYN = 3'd7
    } rmT;

    typedef enum logic [2:0] {NONE, NX, UF, OF, DZ, NV, ILLEGAL} flagT;

    typedef struct packed {
        logic                valid;
        fpuOpT               opcode;
        rmT                  rm;
        logic [`FLEN-1:0]    srcA;
        logic [`FLEN-1:0]    srcB;
        logic [`TAG_W-1:0]   tagDst;
        logic [`SQN_W-1:0]   sqN;
        logic [`XLEN-1:0]    pc;
    } fpUopT;

    typedef struct packed {
        logic                taken;
        logic [`SQN_W-1:0]   sqN;
    } branchT;

    typedef struct packed {
        logic                valid;
        logic [`TAG_W-1:0]   tagDst;
        logic [`SQN_W-1:0]   sqN;
        logic [`XLEN-1:0]    pc;
        logic [`FLEN-1:0]    result;
        flagT                flags;
        logic [4:0]          fflagBits;  // NV DZ OF UF NX
    } fpResT;

    // Increment decision shared by both converters
    function automatic logic roundIncr(input rmT rm, input logic neg, input logic lsb,
                                       input logic guard, input logic sticky);
        case (rm)
            RTZ:     return 1'b0;
            RDN:     return neg & (guard | sticky);
            RUP:     return ~neg & (guard | sticky);
            RMM:     return guard;
            default: return guard & (sticky | lsb);  // RNE
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/fpuDefs.svh
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// ======================================================================
// Datapath widths
// ======================================================================

`define FLEN 32      // Single precision only
`define XLEN 32

// ======================================================================
// Micro-op bookkeeping
// ======================================================================

`define TAG_W 6      // Physical destination tag
`define SQN_W 7      // Sequence number, wraps

// Quiet NaN returned by FMIN/FMAX when both sources are NaN
`define CANON_NAN 32'h7FC00000

`endif
